// File: common/uart_params.svh
//--------------------------------------------------------------------------
// Fixed UART and register map settings for the RTL and the testbench
// Bit period is counted in system clocks and must be even, at least 4
// Receive buffer depth must be at least 2
// Transmit credits match the two transmitter stages and must stay at 2
//--------------------------------------------------------------------------
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Serial bit period in clock cycles
`define UART_CLOCKS_PER_BIT 16

// Receive buffer entries, also the receiver's starting credits
`define UART_RX_DEPTH 4

// Holding plus shift register
`define UART_TX_CREDITS 2

// Register map
`define UART_STATUS_ADDR  32'h8000_0000
`define UART_RX_DATA_ADDR 32'h8000_0004
`define UART_TX_DATA_ADDR 32'h8000_0008

`endif

// File: common/mmio_pkg.sv
//--------------------------------------------------------------------------
// Processor bus types for the serial port register block
// One bus operation per cycle and 32-bit words only
// Status bits above rx_overrun read as zero
//--------------------------------------------------------------------------
`default_nettype none

package mmio_pkg;

    // Bus operation of one cycle
    typedef enum logic [1:0]
    {
        io_idle  = 2'd0,
        io_read  = 2'd1,
        io_write = 2'd2
    } io_op_e;

    // Register selected by the decoded address
    typedef enum logic [1:0]
    {
        reg_status,
        reg_rx_data,
        reg_tx_data,
        reg_none
    } io_reg_e;

    typedef logic [31:0] io_word_t;

    // Bit positions in the status word
    typedef enum int unsigned
    {
        stat_tx_ready   = 0,
        stat_rx_valid   = 1,
        stat_rx_overrun = 2
    } status_bits;

endpackage

`default_nettype wire

// File: common/serial_pkg.sv
//--------------------------------------------------------------------------
// Serial side types for the UART
// Frames are 8N1 only, so one byte type covers both directions
//--------------------------------------------------------------------------
`default_nettype none

package serial_pkg;

    typedef logic [7:0] serial_byte_t;

    // Transmitter frame position
    typedef enum logic [1:0]
    {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_e;

    // Receiver frame position
    typedef enum logic [1:0]
    {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_e;

endpackage

`default_nettype wire

// File: common/byte_stream_if.sv
//--------------------------------------------------------------------------
// Credit based byte channel
// Sender raises valid only while it holds a credit
// Receiver must take every valid byte and pulses credit once per free slot
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;
    import serial_pkg::*;

    logic         valid;
    serial_byte_t data;
    logic         credit;

    modport sender
    (
        output valid,
        output data,
        input  credit
    );

    modport receiver
    (
        input  valid,
        input  data,
        output credit
    );

endinterface

`default_nettype wire

// File: hdl/io_register_file.sv
//--------------------------------------------------------------------------
// Bus facing register block of the serial port
// Read data is registered and appears one cycle after the access
// Unmapped reads and the write-only transmit register read as zero
// Transmit writes without a free credit are silently dropped
// Status read clears the sticky overrun flag unless a new one arrives
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module io_register_file
(
    input  wire                clock,
    input  wire                reset,
    input  wire mmio_pkg::io_op_e op,
    input  wire mmio_pkg::io_word_t addr,
    input  wire mmio_pkg::io_word_t write_data,
    output mmio_pkg::io_word_t read_data,
    byte_stream_if.sender      tx,
    byte_stream_if.receiver    rx,
    input  wire                overrun
);
    import mmio_pkg::*;
    import serial_pkg::*;

    localparam int TX_CW    = $clog2(`UART_TX_CREDITS + 1);
    localparam int RX_DEPTH = `UART_RX_DEPTH;
    localparam int PTR_W    = $clog2(RX_DEPTH);
    localparam int CNT_W    = $clog2(RX_DEPTH + 1);

    io_reg_e          sel;
    logic [TX_CW-1:0] tx_credits;
    logic             tx_ready;
    serial_byte_t     rx_mem [RX_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] rx_count;
    logic             rx_valid;
    logic             rx_pop;
    logic             status_read;
    logic             overrun_flag;
    io_word_t         status_word;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(RX_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    // ----------------------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------------------
    always_comb
    begin
        case (addr)
            `UART_STATUS_ADDR:  sel = reg_status;
            `UART_RX_DATA_ADDR: sel = reg_rx_data;
            `UART_TX_DATA_ADDR: sel = reg_tx_data;
            default:            sel = reg_none;
        endcase
    end

    assign tx_ready    = (tx_credits != '0);
    assign rx_valid    = (rx_count != '0);
    assign status_read = (op == io_read) && (sel == reg_status);
    assign rx_pop      = (op == io_read) && (sel == reg_rx_data) && rx_valid;

    // ----------------------------------------------------------------------
    // Transmit path
    // ----------------------------------------------------------------------
    assign tx.valid = (op == io_write) && (sel == reg_tx_data) && tx_ready;
    assign tx.data  = write_data[7:0];

    always_ff @(posedge clock)
    begin
        if (reset)
            tx_credits <= TX_CW'(`UART_TX_CREDITS);
        else if (tx.valid && !tx.credit)
            tx_credits <= tx_credits - 1'b1;
        else if (!tx.valid && tx.credit)
            tx_credits <= tx_credits + 1'b1;
    end

    // ----------------------------------------------------------------------
    // Receive buffer with one credit handed back per pop
    // ----------------------------------------------------------------------
    assign rx.credit = rx_pop;

    always_ff @(posedge clock)
    begin
        if (rx.valid)
            rx_mem[wr_ptr] <= rx.data;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rx_count <= '0;
        end
        else
        begin
            if (rx.valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (rx_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (rx.valid && !rx_pop)
                rx_count <= rx_count + 1'b1;
            else if (!rx.valid && rx_pop)
                rx_count <= rx_count - 1'b1;
        end
    end

    // New overrun wins over a clearing status read
    always_ff @(posedge clock)
    begin
        if (reset)
            overrun_flag <= 1'b0;
        else if (overrun)
            overrun_flag <= 1'b1;
        else if (status_read)
            overrun_flag <= 1'b0;
    end

    always_comb
    begin
        status_word                  = '0;
        status_word[stat_tx_ready]   = tx_ready;
        status_word[stat_rx_valid]   = rx_valid;
        status_word[stat_rx_overrun] = overrun_flag;
    end

    // Registered read data
    always_ff @(posedge clock)
    begin
        if (reset)
            read_data <= '0;
        else if (status_read)
            read_data <= status_word;
        else if (rx_pop)
            read_data <= {24'b0, rx_mem[rd_ptr]};
        else
            read_data <= '0;
    end

    // Credit accounting on both channels
    assert property (@(posedge clock) disable iff (reset)
        tx.credit |-> tx_credits < TX_CW'(`UART_TX_CREDITS));
    assert property (@(posedge clock) disable iff (reset)
        rx.valid |-> rx_count < CNT_W'(RX_DEPTH));

endmodule

`default_nettype wire

// File: uart/uart_transmitter.sv
//--------------------------------------------------------------------------
// UART transmitter with a holding register in front of the shifter
// Sends 8N1 frames LSB first, each bit `UART_CLOCKS_PER_BIT cycles long
// A credit returns when the shifter finishes a frame
// Back to back frames follow without extra idle time
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_transmitter
(
    input  wire              clock,
    input  wire              reset,
    byte_stream_if.receiver  in,
    output logic             serial_out
);
    import serial_pkg::*;

    localparam int CPB   = `UART_CLOCKS_PER_BIT;
    localparam int CNT_W = $clog2(CPB);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CPB - 1);

    tx_state_e        state;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic             bit_end;
    serial_byte_t     hold;
    logic             hold_full;
    serial_byte_t     shift;
    logic             load;

    assign bit_end = (bit_cnt == LAST);

    // Shifter takes the held byte when idle or at the end of a stop bit
    assign load = hold_full && ((state == tx_idle) || (state == tx_stop && bit_end));

    // A finished frame frees one of the two stages
    assign in.credit = (state == tx_stop) && bit_end;

    // Holding register and its occupied flag
    always_ff @(posedge clock)
    begin
        if (in.valid)
            hold <= in.data;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            hold_full <= 1'b0;
        else if (in.valid)
            hold_full <= 1'b1;
        else if (load)
            hold_full <= 1'b0;
    end

    // ----------------------------------------------------------------------
    // Frame sequencer
    // ----------------------------------------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state      <= tx_idle;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            serial_out <= 1'b1;
        end
        else if (load)
        begin
            shift      <= hold;
            state      <= tx_start;
            bit_cnt    <= '0;
            serial_out <= 1'b0;
        end
        else
        begin
            bit_cnt <= (state == tx_idle || bit_end) ? '0 : bit_cnt + 1'b1;
            case (state)
                tx_start:
                begin
                    if (bit_end)
                    begin
                        state      <= tx_data;
                        bit_idx    <= '0;
                        serial_out <= shift[0];
                    end
                end
                tx_data:
                begin
                    if (bit_end)
                    begin
                        shift   <= {1'b0, shift[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                        begin
                            state      <= tx_stop;
                            serial_out <= 1'b1;
                        end
                        else
                            serial_out <= shift[1];
                    end
                end
                tx_stop:
                begin
                    if (bit_end)
                        state <= tx_idle;
                end
                default:
                    serial_out <= 1'b1;
            endcase
        end
    end

    // Sender holds at most one credit beyond the busy shifter
    assert property (@(posedge clock) disable iff (reset)
        in.valid |-> (!hold_full || load));

endmodule

`default_nettype wire

// File: uart/uart_receiver.sv
//--------------------------------------------------------------------------
// UART receiver for 8N1 frames
// Input passes a two flop synchronizer, bits are sampled at mid period
// Frames with a low stop bit are dropped without any flag
// A good frame with no credit left is dropped and pulses overrun
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_receiver
(
    input  wire            clock,
    input  wire            reset,
    input  wire            serial_in,
    byte_stream_if.sender  out,
    output logic           overrun
);
    import serial_pkg::*;

    localparam int CPB   = `UART_CLOCKS_PER_BIT;
    localparam int CNT_W = $clog2(CPB);
    localparam int CR_W  = $clog2(`UART_RX_DEPTH + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CPB - 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'(CPB / 2 - 1);

    rx_state_e        state;
    logic [1:0]       sync_q;
    logic             rx_bit;
    logic             rx_prev;
    logic             start_edge;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    serial_byte_t     shift;
    logic             frame_ok;
    logic [CR_W-1:0]  credits;

    // Synchronizer idles high like the line
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            sync_q  <= 2'b11;
            rx_prev <= 1'b1;
        end
        else
        begin
            sync_q  <= {sync_q[0], serial_in};
            rx_prev <= sync_q[1];
        end
    end

    assign rx_bit     = sync_q[1];
    assign start_edge = rx_prev && !rx_bit;

    // ----------------------------------------------------------------------
    // Frame sampler
    // ----------------------------------------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state   <= rx_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
        end
        else
        begin
            bit_cnt <= bit_cnt + 1'b1;
            case (state)
                rx_idle:
                begin
                    bit_cnt <= '0;
                    if (start_edge)
                        state <= rx_start;
                end
                rx_start:
                begin
                    // Recheck the start bit at its middle to reject glitches
                    if (bit_cnt == HALF)
                    begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_bit ? rx_idle : rx_data;
                    end
                end
                rx_data:
                begin
                    if (bit_cnt == LAST)
                    begin
                        bit_cnt <= '0;
                        shift   <= {rx_bit, shift[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= rx_stop;
                    end
                end
                default:
                begin
                    if (bit_cnt == LAST)
                        state <= rx_idle;
                end
            endcase
        end
    end

    // Good stop bit sampled this cycle
    assign frame_ok = (state == rx_stop) && (bit_cnt == LAST) && rx_bit;

    assign out.valid = frame_ok && (credits != '0);
    assign out.data  = shift;
    assign overrun   = frame_ok && (credits == '0);

    always_ff @(posedge clock)
    begin
        if (reset)
            credits <= CR_W'(`UART_RX_DEPTH);
        else if (out.valid && !out.credit)
            credits <= credits - 1'b1;
        else if (!out.valid && out.credit)
            credits <= credits + 1'b1;
    end

endmodule

`default_nettype wire

// File: hdl/io_interface.sv
//--------------------------------------------------------------------------
// Memory mapped serial port, top level
// Registers at 0x80000000 (status), 0x80000004 (rx), 0x80000008 (tx)
// serial_in is asynchronous and synchronized inside the receiver
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module io_interface
(
    input  wire                clock,
    input  wire                reset,
    input  wire mmio_pkg::io_op_e op,
    input  wire mmio_pkg::io_word_t addr,
    input  wire mmio_pkg::io_word_t write_data,
    output mmio_pkg::io_word_t read_data,
    input  wire                serial_in,
    output logic               serial_out
);

    // Register file to transmitter, and receiver to register file
    byte_stream_if tx_stream ();
    byte_stream_if rx_stream ();

    logic rx_overrun;

    io_register_file regs
    (
        .clock      (clock),
        .reset      (reset),
        .op         (op),
        .addr       (addr),
        .write_data (write_data),
        .read_data  (read_data),
        .tx         (tx_stream.sender),
        .rx         (rx_stream.receiver),
        .overrun    (rx_overrun)
    );

    uart_transmitter transmitter
    (
        .clock      (clock),
        .reset      (reset),
        .in         (tx_stream.receiver),
        .serial_out (serial_out)
    );

    uart_receiver receiver
    (
        .clock      (clock),
        .reset      (reset),
        .serial_in  (serial_in),
        .out        (rx_stream.sender),
        .overrun    (rx_overrun)
    );

endmodule

`default_nettype wire

// File: sim/tb_io_interface.sv
//--------------------------------------------------------------------------
// Testbench for the memory mapped serial port
// Stands in for the processor on the bus and for the far end of the line
// Inputs change on the falling clock edge, outputs are sampled there too
// Transmit acceptance follows the credit count of the register file
// Needs uart_params.svh on the include path
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module tb_io_interface;
    import mmio_pkg::*;
    import serial_pkg::*;

    localparam int CLOCK_PERIOD = 40;
    localparam int CPB          = `UART_CLOCKS_PER_BIT;
    localparam int RX_DEPTH     = `UART_RX_DEPTH;
    localparam int TX_CREDITS   = `UART_TX_CREDITS;
    localparam io_word_t UNMAPPED_ADDR = 32'h8000_000C;

    // Frames per test that also size the watchdog
    localparam int TX_BYTES     = 8;
    localparam int RX_FRAMES    = 4;
    localparam int BURST_FRAMES = 4;
    localparam int TOTAL_FRAMES = TX_BYTES + RX_FRAMES + RX_DEPTH + 1 + BURST_FRAMES;
    localparam longint WATCHDOG_NS =
        longint'(TOTAL_FRAMES) * 10 * CPB * CLOCK_PERIOD * 2;

    logic     clock;
    logic     reset;
    io_op_e   op;
    io_word_t addr;
    io_word_t write_data;
    io_word_t read_data;
    logic     serial_in;
    logic     serial_out;

    // Reference model state
    serial_byte_t tx_expected [$];
    serial_byte_t tx_seen [$];
    serial_byte_t rx_model [$];
    int           tx_free;
    logic         model_overrun;

    int    value_errors;
    int    protocol_errors;
    string test_name;

    io_interface UUT
    (
        .clock      (clock),
        .reset      (reset),
        .op         (op),
        .addr       (addr),
        .write_data (write_data),
        .read_data  (read_data),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

    initial
    begin
        clock = 1'b0;
        forever
            #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Status word as the register map defines it
    function automatic io_word_t expected_status(input int rx_count, input int free,
                                                 input logic overrun);
        io_word_t word;
        word                  = '0;
        word[stat_tx_ready]   = (free > 0);
        word[stat_rx_valid]   = (rx_count > 0);
        word[stat_rx_overrun] = overrun;
        return word;
    endfunction

    // ----------------------------------------------------------------------
    // Compare and report
    // ----------------------------------------------------------------------
    task automatic check_word(input string what, input io_word_t expected,
                              input io_word_t actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_byte(input string what, input serial_byte_t expected,
                              input serial_byte_t actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("[ERROR] %s %s: expected 0x%02h, actual 0x%02h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        protocol_errors++;
        $display("%s: %s", test_name, msg);
    endtask

    // ----------------------------------------------------------------------
    // Bus side
    // ----------------------------------------------------------------------
    task automatic bus_write(input io_word_t a, input io_word_t data);
        @(negedge clock);
        op         = io_write;
        addr       = a;
        write_data = data;
        @(posedge clock);
        // Byte is taken only against a free credit
        if (a == `UART_TX_DATA_ADDR && tx_free > 0)
        begin
            tx_free--;
            tx_expected.push_back(data[7:0]);
        end
        @(negedge clock);
        op         = io_idle;
        addr       = '0;
        write_data = '0;
    endtask

    // Expected status is taken at the sampling edge of the access
    task automatic bus_read(input io_word_t a, output io_word_t data,
                            output io_word_t status_now);
        @(negedge clock);
        op   = io_read;
        addr = a;
        @(posedge clock);
        status_now = expected_status(rx_model.size(), tx_free, model_overrun);
        @(negedge clock);
        op   = io_idle;
        addr = '0;
        data = read_data;
    endtask

    task automatic status_check(output io_word_t value);
        io_word_t expected;
        bus_read(`UART_STATUS_ADDR, value, expected);
        check_word("status", expected, value);
        // Status read clears the sticky overrun
        model_overrun = 1'b0;
    endtask

    task automatic rx_data_check();
        io_word_t expected;
        io_word_t value;
        io_word_t unused_status;
        expected = '0;
        if (rx_model.size() > 0)
            expected = {24'h0, rx_model.pop_front()};
        bus_read(`UART_RX_DATA_ADDR, value, unused_status);
        check_word("rx data", expected, value);
    endtask

    task automatic poll_status(input int bit_pos, input logic want, input int max_polls);
        io_word_t value;
        int       n;
        status_check(value);
        n = 1;
        while (value[bit_pos] !== want && n < max_polls)
        begin
            status_check(value);
            n++;
        end
        if (value[bit_pos] !== want)
            report_failure($sformatf("status bit %0d never read as %0b", bit_pos, want));
    endtask

    // ----------------------------------------------------------------------
    // Serial side
    // ----------------------------------------------------------------------
    task automatic send_frame(input serial_byte_t data);
        logic [9:0] frame;
        int         k;
        frame = {1'b1, data, 1'b0};
        for (k = 0; k < 10; k++)
        begin
            @(negedge clock);
            serial_in = frame[k];
            repeat (CPB - 1) @(negedge clock);
        end
        // Byte is buffered well before the stop bit ends
        if (rx_model.size() < RX_DEPTH)
            rx_model.push_back(data);
        else
            model_overrun = 1'b1;
    endtask

    task automatic wait_tx_drain();
        int limit;
        int n;
        limit = (tx_expected.size() + 1) * 10 * CPB + 4 * CPB;
        n     = 0;
        while (tx_expected.size() != 0 && n < limit)
        begin
            @(negedge clock);
            n++;
        end
        if (tx_expected.size() != 0)
        begin
            report_failure($sformatf("%0d written bytes never appeared on serial_out",
                                     tx_expected.size()));
            tx_expected.delete();
        end
    endtask

    // Frame decoder on serial_out where every bit must hold for CPB cycles
    initial
    begin : serial_monitor
        logic [9:0] frame;
        logic       steady;
        logic       frame_done;
        int         k;
        int         c;

        frame_done = 1'b0;
        wait (reset === 1'b0);
        forever
        begin
            @(negedge clock);
            // Shifter finished its frame and freed a stage at the last rising edge
            if (frame_done)
            begin
                tx_free++;
                frame_done = 1'b0;
            end
            if (serial_out === 1'b0)
            begin
                steady = 1'b1;
                for (k = 0; k < 10; k++)
                begin
                    if (k != 0)
                        @(negedge clock);
                    frame[k] = serial_out;
                    for (c = 1; c < CPB; c++)
                    begin
                        @(negedge clock);
                        if (serial_out !== frame[k])
                            steady = 1'b0;
                    end
                end
                if (!steady)
                    report_failure("serial_out changed inside a bit period");
                else if (frame[9] !== 1'b1)
                    report_failure("frame on serial_out has no stop bit");
                else
                    tx_seen.push_back(frame[8:1]);
                frame_done = 1'b1;
            end
        end
    end

    initial
    begin : byte_compare
        serial_byte_t got;
        forever
        begin
            @(posedge clock);
            while (tx_seen.size() > 0)
            begin
                got = tx_seen.pop_front();
                if (tx_expected.size() == 0)
                    report_failure($sformatf("unexpected byte 0x%02h on serial_out", got));
                else
                    check_byte("serial_out byte", tx_expected.pop_front(), got);
            end
        end
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns in %s", WATCHDOG_NS, test_name);
        $display("Some tests failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial
    begin : stimulus
        io_word_t     value;
        io_word_t     unused_status;
        serial_byte_t b;
        int           i;

        void'($urandom(46));
        reset           = 1'b1;
        op              = io_idle;
        addr            = '0;
        write_data      = '0;
        serial_in       = 1'b1;
        value_errors    = 0;
        protocol_errors = 0;
        tx_free         = TX_CREDITS;
        model_overrun   = 1'b0;
        test_name       = "reset";
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_name = "after reset";
        check_word("read_data", '0, read_data);
        status_check(value);
        for (i = 0; i < 2 * CPB; i++)
        begin
            @(negedge clock);
            if (serial_out !== 1'b1)
                report_failure("serial_out left idle high");
        end
        rx_data_check();
        bus_read(UNMAPPED_ADDR, value, unused_status);
        check_word("unmapped read", '0, value);

        test_name = "polled transmit";
        for (i = 0; i < TX_BYTES; i++)
        begin
            poll_status(stat_tx_ready, 1'b1, 2 * 10 * CPB);
            b = serial_byte_t'($urandom & 32'hFF);
            bus_write(`UART_TX_DATA_ADDR, {24'h0, b});
        end
        wait_tx_drain();

        test_name = "single receive";
        for (i = 0; i < RX_FRAMES; i++)
        begin
            b = serial_byte_t'($urandom & 32'hFF);
            send_frame(b);
            poll_status(stat_rx_valid, 1'b1, 8);
            rx_data_check();
            status_check(value);
        end

        test_name = "receive overrun";
        for (i = 0; i <= RX_DEPTH; i++)
            send_frame(serial_byte_t'($urandom & 32'hFF));
        status_check(value);
        for (i = 0; i < RX_DEPTH; i++)
            rx_data_check();
        status_check(value);

        test_name = "transmit burst";
        bus_write(`UART_TX_DATA_ADDR, $urandom & 32'hFF);
        i = 0;
        while (serial_out !== 1'b0 && i < 4 * CPB)
        begin
            @(negedge clock);
            i++;
        end
        repeat (2) @(negedge clock);
        for (i = 0; i < BURST_FRAMES - 1; i++)
            bus_write(`UART_TX_DATA_ADDR, $urandom & 32'hFF);
        status_check(value);
        wait_tx_drain();
        poll_status(stat_tx_ready, 1'b1, 4);

        repeat (4) @(negedge clock);
        $display("Errors: %0d value mismatches, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/mmio_pkg.sv
common/serial_pkg.sv
common/byte_stream_if.sv
hdl/io_register_file.sv
uart/uart_transmitter.sv
uart/uart_receiver.sv
hdl/io_interface.sv
sim/tb_io_interface.sv

// File: Bender.yml
package:
  name: io_interface

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mmio_pkg.sv
      - common/serial_pkg.sv
      - common/byte_stream_if.sv
      - hdl/io_register_file.sv
      - uart/uart_transmitter.sv
      - uart/uart_receiver.sv
      - hdl/io_interface.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_io_interface.sv
